//--- hdl/id_config.svh
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

//////////////////////////////
// Decode stage dimensions
//////////////////////////////

// Data path and PC width
`define ID_XLEN 32

// Register file address width
// 32 architectural registers
`define ID_REG_AW 5

// Link offset for a 32-bit instruction
// No compressed instructions in this core
`define ID_PC_INCR 32'd4

`endif

//--- hdl/rv_isa_pkg.sv
`include "id_config.svh"

package rv_isa_pkg;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  // Only the kept RV32I subset
  typedef enum logic [6:0] {
    OPCODE_OP_IMM = 7'h13,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU function field, shared by OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  //////////////////////////////
  // Instruction field positions
  //////////////////////////////

  localparam int unsigned FUNCT7_MSB = 31;
  localparam int unsigned FUNCT7_LSB = 25;
  localparam int unsigned RS2_MSB    = 24;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned RS1_MSB    = 19;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned FUNCT3_MSB = 14;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RD_MSB     = 11;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned OPCODE_MSB = 6;

  // funct7 encodings, ALT picks SUB and SRA
  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;

  // Hardwired zero register
  localparam logic [`ID_REG_AW-1:0] REG_X0 = '0;

endpackage

//--- hdl/id_ctrl_pkg.sv
package id_ctrl_pkg;

  //////////////////////////////
  // ALU operation
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_SLL  = 4'h2,
    ALU_SLT  = 4'h3,
    ALU_SLTU = 4'h4,
    ALU_XOR  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_OR   = 4'h8,
    ALU_AND  = 4'h9
  } alu_op_e;

  // Value held by the ID/EX register out of reset
  localparam alu_op_e ALU_OP_RESET = ALU_SLTU;

  //////////////////////////////
  // Operand and immediate selects
  //////////////////////////////

  // NONE means EX does not use the operand
  typedef enum logic [1:0] {
    OP_A_NONE = 2'd0,
    OP_A_REG  = 2'd1,
    OP_A_PC   = 2'd2,
    OP_A_ZERO = 2'd3
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_NONE   = 2'd0,
    OP_B_REG    = 2'd1,
    OP_B_IMM    = 2'd2,
    OP_B_PCINCR = 2'd3
  } op_b_sel_e;

  typedef enum logic [1:0] {
    IMM_I = 2'd0,
    IMM_U = 2'd1,
    IMM_J = 2'd2
  } imm_sel_e;

  // Bypass source, driven by the controller
  typedef enum logic [1:0] {
    FWD_REGFILE = 2'd0,
    FWD_EX      = 2'd1,
    FWD_WB      = 2'd2
  } fwd_sel_e;

endpackage

//--- hdl/id_decoder.sv
`include "id_config.svh"

module id_decoder (
  input  logic [`ID_XLEN-1:0]     instr_i,
  output id_ctrl_pkg::alu_op_e    alu_op_o,
  output id_ctrl_pkg::op_a_sel_e  op_a_sel_o,
  output id_ctrl_pkg::op_b_sel_e  op_b_sel_o,
  output id_ctrl_pkg::imm_sel_e   imm_sel_o,
  output logic                    rf_we_o,
  output logic [1:0]              rf_re_o,
  output logic                    jmp_o,
  output logic                    illegal_o
);

  rv_isa_pkg::opcode_e   opcode;
  rv_isa_pkg::funct3_e   funct3;
  logic [6:0]            funct7;
  logic [`ID_REG_AW-1:0] rd;
  logic                  f7_base;
  logic                  f7_alt;
  logic                  writes_rd;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic id_ctrl_pkg::alu_op_e alu_op_map(input rv_isa_pkg::funct3_e f3,
                                                      input logic alt);
    id_ctrl_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: op = alt ? id_ctrl_pkg::ALU_SUB : id_ctrl_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = id_ctrl_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = id_ctrl_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = id_ctrl_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = id_ctrl_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = id_ctrl_pkg::ALU_OR;
      default:                op = id_ctrl_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // Field extraction
  assign opcode  = rv_isa_pkg::opcode_e'(instr_i[rv_isa_pkg::OPCODE_MSB:0]);
  assign funct3  = rv_isa_pkg::funct3_e'(instr_i[rv_isa_pkg::FUNCT3_MSB:rv_isa_pkg::FUNCT3_LSB]);
  assign funct7  = instr_i[rv_isa_pkg::FUNCT7_MSB:rv_isa_pkg::FUNCT7_LSB];
  assign rd      = instr_i[rv_isa_pkg::RD_MSB:rv_isa_pkg::RD_LSB];
  assign f7_base = (funct7 == rv_isa_pkg::FUNCT7_BASE);
  assign f7_alt  = (funct7 == rv_isa_pkg::FUNCT7_ALT);

  //////////////////////////////
  // Main decode
  //////////////////////////////

  always_comb begin
    alu_op_o   = id_ctrl_pkg::ALU_ADD;
    op_a_sel_o = id_ctrl_pkg::OP_A_NONE;
    op_b_sel_o = id_ctrl_pkg::OP_B_NONE;
    imm_sel_o  = id_ctrl_pkg::IMM_I;
    rf_re_o    = 2'b00;
    jmp_o      = 1'b0;
    writes_rd  = 1'b0;
    illegal_o  = 1'b0;

    case (opcode)
      rv_isa_pkg::OPCODE_OP_IMM: begin
        op_a_sel_o = id_ctrl_pkg::OP_A_REG;
        op_b_sel_o = id_ctrl_pkg::OP_B_IMM;
        rf_re_o    = 2'b01;
        writes_rd  = 1'b1;
        // No SUBI, only shifts look at funct7
        alu_op_o   = alu_op_map(funct3, f7_alt && (funct3 == rv_isa_pkg::F3_SRL_SRA));
        if (funct3 == rv_isa_pkg::F3_SLL) begin
          illegal_o = !f7_base;
        end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          illegal_o = !(f7_base || f7_alt);
        end
      end
      rv_isa_pkg::OPCODE_OP: begin
        op_a_sel_o = id_ctrl_pkg::OP_A_REG;
        op_b_sel_o = id_ctrl_pkg::OP_B_REG;
        rf_re_o    = 2'b11;
        writes_rd  = 1'b1;
        alu_op_o   = alu_op_map(funct3, f7_alt);
        // ALT only valid for SUB and SRA
        illegal_o  = !(f7_base || (f7_alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                              funct3 == rv_isa_pkg::F3_SRL_SRA)));
      end
      rv_isa_pkg::OPCODE_LUI: begin
        op_a_sel_o = id_ctrl_pkg::OP_A_ZERO;
        op_b_sel_o = id_ctrl_pkg::OP_B_IMM;
        imm_sel_o  = id_ctrl_pkg::IMM_U;
        writes_rd  = 1'b1;
      end
      rv_isa_pkg::OPCODE_AUIPC: begin
        op_a_sel_o = id_ctrl_pkg::OP_A_PC;
        op_b_sel_o = id_ctrl_pkg::OP_B_IMM;
        imm_sel_o  = id_ctrl_pkg::IMM_U;
        writes_rd  = 1'b1;
      end
      rv_isa_pkg::OPCODE_JAL: begin
        // ALU forms the link address PC + 4
        op_a_sel_o = id_ctrl_pkg::OP_A_PC;
        op_b_sel_o = id_ctrl_pkg::OP_B_PCINCR;
        imm_sel_o  = id_ctrl_pkg::IMM_J;
        writes_rd  = 1'b1;
        jmp_o      = 1'b1;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase

    // Illegal overrides everything decoded above
    if (illegal_o) begin
      op_a_sel_o = id_ctrl_pkg::OP_A_NONE;
      op_b_sel_o = id_ctrl_pkg::OP_B_NONE;
      rf_re_o    = 2'b11;
      writes_rd  = 1'b0;
      jmp_o      = 1'b0;
    end
  end

  // Writes to x0 are dropped here
  assign rf_we_o = writes_rd && (rd != rv_isa_pkg::REG_X0);

  // Illegal encodings must never reach the register file or redirect fetch
  a_illegal_no_effect: assert property (@(instr_i)
    illegal_o |-> (!rf_we_o && !jmp_o && rf_re_o == 2'b11));

endmodule

//--- hdl/id_operand_select.sv
`include "id_config.svh"

module id_operand_select (
  input  logic [`ID_XLEN-1:0]    instr_i,
  input  logic [`ID_XLEN-1:0]    pc_i,
  input  id_ctrl_pkg::imm_sel_e  imm_sel_i,
  input  id_ctrl_pkg::op_a_sel_e op_a_sel_i,
  input  id_ctrl_pkg::op_b_sel_e op_b_sel_i,
  input  id_ctrl_pkg::fwd_sel_e  fwd_a_sel_i,
  input  id_ctrl_pkg::fwd_sel_e  fwd_b_sel_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0]    rf_wdata_ex_i,
  input  logic [`ID_XLEN-1:0]    rf_wdata_wb_i,
  output logic [`ID_XLEN-1:0]    operand_a_o,
  output logic [`ID_XLEN-1:0]    operand_b_o,
  output logic [`ID_XLEN-1:0]    jmp_target_o
);

  // Instruction sign bit sits at the top of funct7
  localparam int unsigned SB = rv_isa_pkg::FUNCT7_MSB;

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;
  logic [`ID_XLEN-1:0] imm;
  logic [`ID_XLEN-1:0] rs1_fw;
  logic [`ID_XLEN-1:0] rs2_fw;

  // Bypass mux, same for both sources
  function automatic logic [`ID_XLEN-1:0] fwd_mux(input id_ctrl_pkg::fwd_sel_e sel,
                                                 input logic [`ID_XLEN-1:0] rf,
                                                 input logic [`ID_XLEN-1:0] ex,
                                                 input logic [`ID_XLEN-1:0] wb);
    logic [`ID_XLEN-1:0] res;
    case (sel)
      id_ctrl_pkg::FWD_EX: res = ex;
      id_ctrl_pkg::FWD_WB: res = wb;
      default:             res = rf;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Immediates
  //////////////////////////////

  // I type, bits 31:20
  assign imm_i = {{(`ID_XLEN-12){instr_i[SB]}}, instr_i[SB:rv_isa_pkg::RS2_LSB]};

  // U type, upper 20 bits
  assign imm_u = {instr_i[SB:rv_isa_pkg::FUNCT3_LSB], 12'b0};

  // J type, scrambled 20-bit offset in halfwords
  assign imm_j = {{(`ID_XLEN-20){instr_i[SB]}},
                  instr_i[rv_isa_pkg::RS1_MSB:rv_isa_pkg::FUNCT3_LSB],
                  instr_i[rv_isa_pkg::RS2_LSB],
                  instr_i[SB-1:rv_isa_pkg::RS2_LSB+1],
                  1'b0};

  always_comb begin
    case (imm_sel_i)
      id_ctrl_pkg::IMM_U: imm = imm_u;
      id_ctrl_pkg::IMM_J: imm = imm_j;
      default:            imm = imm_i;
    endcase
  end

  //////////////////////////////
  // Forwarding and operands
  //////////////////////////////

  assign rs1_fw = fwd_mux(fwd_a_sel_i, rf_rdata_a_i, rf_wdata_ex_i, rf_wdata_wb_i);
  assign rs2_fw = fwd_mux(fwd_b_sel_i, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i);

  always_comb begin
    case (op_a_sel_i)
      id_ctrl_pkg::OP_A_REG: operand_a_o = rs1_fw;
      id_ctrl_pkg::OP_A_PC:  operand_a_o = pc_i;
      // ZERO and unused
      default:               operand_a_o = '0;
    endcase
  end

  always_comb begin
    case (op_b_sel_i)
      id_ctrl_pkg::OP_B_REG:    operand_b_o = rs2_fw;
      id_ctrl_pkg::OP_B_IMM:    operand_b_o = imm;
      id_ctrl_pkg::OP_B_PCINCR: operand_b_o = `ID_PC_INCR;
      default:                  operand_b_o = '0;
    endcase
  end

  // JAL target, resolved in ID
  assign jmp_target_o = pc_i + imm_j;

endmodule

//--- hdl/id_ex_pipe_reg.sv
`include "id_config.svh"

module id_ex_pipe_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    instr_valid_i,
  input  logic                    kill_i,
  input  logic                    halt_i,
  input  logic                    ex_ready_i,
  input  logic                    illegal_i,
  input  logic                    rf_we_i,
  input  id_ctrl_pkg::alu_op_e    alu_op_i,
  input  id_ctrl_pkg::op_a_sel_e  op_a_sel_i,
  input  id_ctrl_pkg::op_b_sel_e  op_b_sel_i,
  input  logic [`ID_XLEN-1:0]     operand_a_i,
  input  logic [`ID_XLEN-1:0]     operand_b_i,
  input  logic [`ID_XLEN-1:0]     pc_i,
  input  logic [`ID_REG_AW-1:0]   rf_waddr_i,
  output logic                    id_valid_o,
  output logic                    id_ready_o,
  output logic                    ex_valid_o,
  output id_ctrl_pkg::alu_op_e    ex_alu_op_o,
  output logic [`ID_XLEN-1:0]     ex_operand_a_o,
  output logic [`ID_XLEN-1:0]     ex_operand_b_o,
  output logic [`ID_XLEN-1:0]     ex_pc_o,
  output logic                    ex_rf_we_o,
  output logic                    ex_illegal_o,
  output logic [`ID_REG_AW-1:0]   ex_rf_waddr_o
);

  logic transfer;

  // Halt stalls ID, kill flushes it and lets fetch move on
  assign id_valid_o = instr_valid_i && !kill_i && !halt_i;
  assign id_ready_o = kill_i || (ex_ready_i && !halt_i);
  assign transfer   = id_valid_o && ex_ready_i;

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (rst_n == 1'b0) begin
      ex_valid_o     <= 1'b0;
      ex_alu_op_o    <= id_ctrl_pkg::ALU_OP_RESET;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_pc_o        <= '0;
      ex_rf_we_o     <= 1'b0;
      ex_illegal_o   <= 1'b0;
      ex_rf_waddr_o  <= rv_isa_pkg::REG_X0;
    end else if (transfer) begin
      ex_valid_o   <= 1'b1;
      ex_alu_op_o  <= alu_op_i;
      ex_rf_we_o   <= rf_we_i;
      ex_illegal_o <= illegal_i;
      ex_pc_o      <= pc_i;
      // Unused operands keep their old value to save toggling
      if (op_a_sel_i != id_ctrl_pkg::OP_A_NONE) begin
        ex_operand_a_o <= operand_a_i;
      end
      if (op_b_sel_i != id_ctrl_pkg::OP_B_NONE) begin
        ex_operand_b_o <= operand_b_i;
      end
      if (rf_we_i) begin
        ex_rf_waddr_o <= rf_waddr_i;
      end
    end else if (ex_ready_i) begin
      // EX consumed its entry, nothing new from ID
      ex_valid_o <= 1'b0;
    end
  end

  // Back-pressure holds the whole EX entry
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && !ex_ready_i) |=> $stable({ex_valid_o, ex_alu_op_o, ex_operand_a_o,
                                             ex_operand_b_o, ex_pc_o, ex_rf_we_o,
                                             ex_illegal_o, ex_rf_waddr_o}));

  // A killed instruction never counts as valid
  a_kill_not_valid: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> !id_valid_o);

endmodule

//--- hdl/id_stage_top.sv
`include "id_config.svh"

module id_stage_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // Fetch side
  input  logic                    instr_valid_i,
  input  logic [`ID_XLEN-1:0]     instr_i,
  input  logic [`ID_XLEN-1:0]     pc_i,
  output logic                    id_ready_o,
  // Controller
  input  logic                    kill_i,
  input  logic                    halt_i,
  input  id_ctrl_pkg::fwd_sel_e   fwd_a_sel_i,
  input  id_ctrl_pkg::fwd_sel_e   fwd_b_sel_i,
  // Register file and bypass data
  output logic [`ID_REG_AW-1:0]   rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]   rf_raddr_b_o,
  output logic [1:0]              rf_re_o,
  input  logic [`ID_XLEN-1:0]     rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]     rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0]     rf_wdata_ex_i,
  input  logic [`ID_XLEN-1:0]     rf_wdata_wb_i,
  // EX side
  output logic                    id_valid_o,
  input  logic                    ex_ready_i,
  output logic                    ex_valid_o,
  output id_ctrl_pkg::alu_op_e    ex_alu_op_o,
  output logic [`ID_XLEN-1:0]     ex_operand_a_o,
  output logic [`ID_XLEN-1:0]     ex_operand_b_o,
  output logic [`ID_XLEN-1:0]     ex_pc_o,
  output logic                    ex_rf_we_o,
  output logic                    ex_illegal_o,
  output logic [`ID_REG_AW-1:0]   ex_rf_waddr_o,
  // Jump to fetch
  output logic                    jmp_o,
  output logic [`ID_XLEN-1:0]     jmp_target_o
);

  id_ctrl_pkg::alu_op_e   alu_op;
  id_ctrl_pkg::op_a_sel_e op_a_sel;
  id_ctrl_pkg::op_b_sel_e op_b_sel;
  id_ctrl_pkg::imm_sel_e  imm_sel;
  logic                   rf_we;
  logic                   illegal;
  logic [`ID_REG_AW-1:0]  rf_waddr;
  logic [`ID_XLEN-1:0]    operand_a;
  logic [`ID_XLEN-1:0]    operand_b;

  // Register addresses straight from the instruction word
  assign rf_raddr_a_o = instr_i[rv_isa_pkg::RS1_MSB:rv_isa_pkg::RS1_LSB];
  assign rf_raddr_b_o = instr_i[rv_isa_pkg::RS2_MSB:rv_isa_pkg::RS2_LSB];
  assign rf_waddr     = instr_i[rv_isa_pkg::RD_MSB:rv_isa_pkg::RD_LSB];

  id_decoder id_decoder_inst (
    .instr_i    (instr_i),
    .alu_op_o   (alu_op),
    .op_a_sel_o (op_a_sel),
    .op_b_sel_o (op_b_sel),
    .imm_sel_o  (imm_sel),
    .rf_we_o    (rf_we),
    .rf_re_o    (rf_re_o),
    .jmp_o      (jmp_o),
    .illegal_o  (illegal)
  );

  id_operand_select id_operand_select_inst (
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .imm_sel_i     (imm_sel),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .fwd_a_sel_i   (fwd_a_sel_i),
    .fwd_b_sel_i   (fwd_b_sel_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .jmp_target_o  (jmp_target_o)
  );

  id_ex_pipe_reg id_ex_pipe_reg_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .ex_ready_i     (ex_ready_i),
    .illegal_i      (illegal),
    .rf_we_i        (rf_we),
    .alu_op_i       (alu_op),
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .pc_i           (pc_i),
    .rf_waddr_i     (rf_waddr),
    .id_valid_o     (id_valid_o),
    .id_ready_o     (id_ready_o),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_pc_o        (ex_pc_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o)
  );

endmodule

//--- sim/tb_id_stage.sv
module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD        = 40;
  // Roughly two cycles per instruction plus reset and stall windows
  localparam int TEST_CYCLES   = 80;
  localparam int MARGIN_CYCLES = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        kill;
  logic        halt;
  logic        ex_ready;
  id_ctrl_pkg::fwd_sel_e fwd_a;
  id_ctrl_pkg::fwd_sel_e fwd_b;
  logic [31:0] wdata_ex;
  logic [31:0] wdata_wb;
  logic [4:0]  raddr_a;
  logic [4:0]  raddr_b;
  logic [1:0]  rf_re;
  logic        id_ready;
  logic        id_valid;
  logic        ex_valid;
  logic        ex_rf_we;
  logic        ex_illegal;
  logic        jmp;
  id_ctrl_pkg::alu_op_e ex_alu_op;
  logic [31:0] ex_op_a;
  logic [31:0] ex_op_b;
  logic [31:0] ex_pc;
  logic [31:0] jmp_target;
  logic [4:0]  ex_waddr;

  // Model register file, answers in the same cycle
  logic [31:0] rf_model [32];
  logic [31:0] next_pc;
  int          errors;
  int          checks;

  id_stage_top id_stage_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .id_ready_o     (id_ready),
    .kill_i         (kill),
    .halt_i         (halt),
    .fwd_a_sel_i    (fwd_a),
    .fwd_b_sel_i    (fwd_b),
    .rf_raddr_a_o   (raddr_a),
    .rf_raddr_b_o   (raddr_b),
    .rf_re_o        (rf_re),
    .rf_rdata_a_i   (rf_model[raddr_a]),
    .rf_rdata_b_i   (rf_model[raddr_b]),
    .rf_wdata_ex_i  (wdata_ex),
    .rf_wdata_wb_i  (wdata_wb),
    .id_valid_o     (id_valid),
    .ex_ready_i     (ex_ready),
    .ex_valid_o     (ex_valid),
    .ex_alu_op_o    (ex_alu_op),
    .ex_operand_a_o (ex_op_a),
    .ex_operand_b_o (ex_op_b),
    .ex_pc_o        (ex_pc),
    .ex_rf_we_o     (ex_rf_we),
    .ex_illegal_o   (ex_illegal),
    .ex_rf_waddr_o  (ex_waddr),
    .jmp_o          (jmp),
    .jmp_target_o   (jmp_target)
  );

  always #(PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Encoders and reference rules
  //////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv_isa_pkg::OPCODE_OP_IMM};
  endfunction

  // J offset bits scattered as in the ISA manual
  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPCODE_JAL};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // Which value a source should carry under a forward select
  function automatic logic [31:0] fwd_value(input id_ctrl_pkg::fwd_sel_e sel,
                                            input logic [31:0] rf_val);
    if (sel == id_ctrl_pkg::FWD_EX) begin
      return wdata_ex;
    end else if (sel == id_ctrl_pkg::FWD_WB) begin
      return wdata_wb;
    end
    return rf_val;
  endfunction

  task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
    checks++;
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, act, exp);
      errors++;
    end
  endtask

  // Drive one instruction at a falling edge
  task automatic present(input logic [31:0] word);
    instr_valid = 1'b1;
    instr       = word;
    pc          = next_pc;
  endtask

  // Wait for the transfer edge, then step to the next falling edge
  task automatic await_transfer();
    #1;
    while (!(id_valid && ex_ready)) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    @(negedge clk);
    instr_valid = 1'b0;
    next_pc     = next_pc + 32'd4;
  endtask

  task automatic send(input logic [31:0] word);
    present(word);
    await_transfer();
  endtask

  task automatic check_ex(input id_ctrl_pkg::alu_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic [4:0] rd,
                          input logic [31:0] pc_exp, input string msg);
    check(ex_valid, 1'b1, {msg, " valid"});
    check(ex_alu_op, op, {msg, " alu op"});
    check(ex_op_a, a, {msg, " operand a"});
    check(ex_op_b, b, {msg, " operand b"});
    check(ex_pc, pc_exp, {msg, " pc"});
    check(ex_rf_we, 1'b1, {msg, " write enable"});
    check(ex_waddr, rd, {msg, " rd"});
    check(ex_illegal, 1'b0, {msg, " illegal"});
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic run_reg_op(input logic [2:0] f3, input logic [6:0] f7,
                            input id_ctrl_pkg::alu_op_e op,
                            input id_ctrl_pkg::fwd_sel_e fa, input id_ctrl_pkg::fwd_sel_e fb);
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] cur_pc;
    rs1    = 5'($urandom);
    rs2    = 5'($urandom);
    rd     = 5'($urandom_range(31, 1));
    fwd_a  = fa;
    fwd_b  = fb;
    cur_pc = next_pc;
    send(enc_r(f7, rs2, rs1, f3, rd));
    check_ex(op, fwd_value(fa, rf_model[rs1]), fwd_value(fb, rf_model[rs2]), rd, cur_pc,
             "reg op");
    fwd_a = id_ctrl_pkg::FWD_REGFILE;
    fwd_b = id_ctrl_pkg::FWD_REGFILE;
  endtask

  task automatic run_imm_op(input logic [2:0] f3, input logic [11:0] imm,
                            input id_ctrl_pkg::alu_op_e op, input id_ctrl_pkg::fwd_sel_e fa);
    logic [4:0]  rs1;
    logic [4:0]  rd;
    logic [31:0] cur_pc;
    rs1    = 5'($urandom);
    rd     = 5'($urandom_range(31, 1));
    fwd_a  = fa;
    cur_pc = next_pc;
    send(enc_i(imm, rs1, f3, rd));
    check_ex(op, fwd_value(fa, rf_model[rs1]), sext12(imm), rd, cur_pc, "imm op");
    fwd_a = id_ctrl_pkg::FWD_REGFILE;
  endtask

  task automatic test_alu();
    run_reg_op(3'b000, 7'h00, id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::FWD_REGFILE,
               id_ctrl_pkg::FWD_REGFILE);
    run_reg_op(3'b000, 7'h20, id_ctrl_pkg::ALU_SUB, id_ctrl_pkg::FWD_EX, id_ctrl_pkg::FWD_WB);
    run_reg_op(3'b001, 7'h00, id_ctrl_pkg::ALU_SLL, id_ctrl_pkg::FWD_WB, id_ctrl_pkg::FWD_EX);
    run_reg_op(3'b010, 7'h00, id_ctrl_pkg::ALU_SLT, id_ctrl_pkg::FWD_REGFILE,
               id_ctrl_pkg::FWD_EX);
    run_reg_op(3'b011, 7'h00, id_ctrl_pkg::ALU_SLTU, id_ctrl_pkg::FWD_EX,
               id_ctrl_pkg::FWD_REGFILE);
    run_reg_op(3'b100, 7'h00, id_ctrl_pkg::ALU_XOR, id_ctrl_pkg::FWD_REGFILE,
               id_ctrl_pkg::FWD_WB);
    run_reg_op(3'b101, 7'h00, id_ctrl_pkg::ALU_SRL, id_ctrl_pkg::FWD_REGFILE,
               id_ctrl_pkg::FWD_REGFILE);
    run_reg_op(3'b101, 7'h20, id_ctrl_pkg::ALU_SRA, id_ctrl_pkg::FWD_WB, id_ctrl_pkg::FWD_WB);
    run_reg_op(3'b110, 7'h00, id_ctrl_pkg::ALU_OR, id_ctrl_pkg::FWD_EX, id_ctrl_pkg::FWD_EX);
    run_reg_op(3'b111, 7'h00, id_ctrl_pkg::ALU_AND, id_ctrl_pkg::FWD_REGFILE,
               id_ctrl_pkg::FWD_REGFILE);
    // Negative immediates check the sign extension
    run_imm_op(3'b000, 12'h8a5, id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::FWD_REGFILE);
    run_imm_op(3'b010, 12'h7ff, id_ctrl_pkg::ALU_SLT, id_ctrl_pkg::FWD_EX);
    run_imm_op(3'b100, 12'hfff, id_ctrl_pkg::ALU_XOR, id_ctrl_pkg::FWD_WB);
    run_imm_op(3'b001, 12'h01f, id_ctrl_pkg::ALU_SLL, id_ctrl_pkg::FWD_REGFILE);
    run_imm_op(3'b101, 12'h007, id_ctrl_pkg::ALU_SRL, id_ctrl_pkg::FWD_REGFILE);
    // SRAI carries funct7 0100000 in the immediate
    run_imm_op(3'b101, 12'h40c, id_ctrl_pkg::ALU_SRA, id_ctrl_pkg::FWD_EX);
    run_imm_op(3'b111, 12'hc30, id_ctrl_pkg::ALU_AND, id_ctrl_pkg::FWD_REGFILE);
  endtask

  task automatic test_upper();
    logic [31:0] cur_pc;
    logic [20:0] off;
    cur_pc = next_pc;
    send({20'hdead5, 5'd3, rv_isa_pkg::OPCODE_LUI});
    check_ex(id_ctrl_pkg::ALU_ADD, 32'd0, 32'hdead_5000, 5'd3, cur_pc, "lui");
    cur_pc = next_pc;
    send({20'h8001f, 5'd9, rv_isa_pkg::OPCODE_AUIPC});
    check_ex(id_ctrl_pkg::ALU_ADD, cur_pc, 32'h8001_f000, 5'd9, cur_pc, "auipc");
    // One forward and one backward jump
    for (int n = 0; n < 2; n++) begin
      off    = (n == 0) ? 21'h0_2468 : 21'h1f_f0f0;
      cur_pc = next_pc;
      present(enc_j(off, 5'd1));
      #1;
      check(jmp, 1'b1, "jal jmp_o in ID");
      check(jmp_target, cur_pc + {{11{off[20]}}, off}, "jal target in ID");
      await_transfer();
      check_ex(id_ctrl_pkg::ALU_ADD, cur_pc, 32'd4, 5'd1, cur_pc, "jal link");
    end
  endtask

  task automatic test_backpressure();
    logic [4:0]  rs1;
    logic [31:0] held_pc;
    logic [31:0] wait_pc;
    rs1     = 5'd7;
    held_pc = next_pc;
    send(enc_i(12'h123, rs1, 3'b000, 5'd12));
    wait_pc  = next_pc;
    ex_ready = 1'b0;
    present(enc_r(7'h00, 5'd4, 5'd5, 3'b110, 5'd13));
    #1;
    check(id_ready, 1'b0, "id_ready under back-pressure");
    // The older entry must sit still for a few cycles
    repeat (3) begin
      @(negedge clk);
      check_ex(id_ctrl_pkg::ALU_ADD, rf_model[rs1], 32'h123, 5'd12, held_pc, "held entry");
    end
    ex_ready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    instr_valid = 1'b0;
    next_pc     = next_pc + 32'd4;
    check_ex(id_ctrl_pkg::ALU_OR, rf_model[5], rf_model[4], 5'd13, wait_pc, "released entry");
  endtask

  task automatic test_kill_halt();
    instr_valid = 1'b1;
    instr       = enc_i(12'h055, 5'd2, 3'b000, 5'd6);
    halt        = 1'b1;
    #1;
    check(id_valid, 1'b0, "id_valid under halt");
    check(id_ready, 1'b0, "id_ready under halt");
    @(negedge clk);
    check(ex_valid, 1'b0, "ex_valid drops during halt");
    // Kill frees fetch even while EX stalls
    halt     = 1'b0;
    kill     = 1'b1;
    ex_ready = 1'b0;
    #1;
    check(id_ready, 1'b1, "id_ready under kill");
    check(id_valid, 1'b0, "id_valid under kill");
    @(negedge clk);
    ex_ready = 1'b1;
    #1;
    check(id_valid, 1'b0, "id_valid under kill with EX ready");
    @(negedge clk);
    check(ex_valid, 1'b0, "killed instruction not captured");
    kill        = 1'b0;
    instr_valid = 1'b0;
  endtask

  task automatic test_illegal();
    // Opcode 7f is outside the subset
    present(32'h0042_8a7f);
    #1;
    check(rf_re, 2'b11, "illegal rf_re");
    await_transfer();
    check(ex_valid, 1'b1, "illegal valid");
    check(ex_illegal, 1'b1, "illegal flag");
    check(ex_rf_we, 1'b0, "illegal write enable");
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  initial begin
    void'($urandom(32'hc87d_62fa));
    errors      = 0;
    checks      = 0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    next_pc     = 32'h0000_1000;
    kill        = 1'b0;
    halt        = 1'b0;
    ex_ready    = 1'b1;
    fwd_a       = id_ctrl_pkg::FWD_REGFILE;
    fwd_b       = id_ctrl_pkg::FWD_REGFILE;
    wdata_ex    = $urandom;
    wdata_wb    = $urandom;
    for (int i = 0; i < 32; i++) begin
      rf_model[i] = (i == 0) ? 32'd0 : $urandom;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check(ex_valid, 1'b0, "reset ex_valid");
    check(ex_rf_we, 1'b0, "reset ex_rf_we");
    check(ex_alu_op, id_ctrl_pkg::ALU_SLTU, "reset ex_alu_op");
    test_alu();
    test_upper();
    test_backpressure();
    test_kill_halt();
    test_illegal();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the test length
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD);
    $display("Timeout: the tests did not finish, the DUT stopped accepting instructions");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_select.sv
hdl/id_ex_pipe_reg.sv
hdl/id_stage_top.sv
sim/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/id_ctrl_pkg.sv
      - hdl/id_decoder.sv
      - hdl/id_operand_select.sv
      - hdl/id_ex_pipe_reg.sv
      - hdl/id_stage_top.sv
  - target: simulation
    files:
      - sim/tb_id_stage.sv
